// File: arb_cfg.svh
`ifndef ARB_CFG_SVH
`define ARB_CFG_SVH

// number of request sources, need not be a power of two
`define ARB_NUM_SRC 4

// width of one data word per source
`define ARB_DATA_W 16

// number of grant records the fifo can hold
`define ARB_FIFO_DEPTH 8

`endif

// File: arb_pkg.sv
`include "arb_cfg.svh"

package arb_pkg;

    // index of one request source
    typedef logic [$clog2(`ARB_NUM_SRC)-1:0] src_id_t;

    // one data word
    typedef logic [`ARB_DATA_W-1:0] data_t;

    // data words of all sources, element i belongs to source i
    typedef data_t [`ARB_NUM_SRC-1:0] req_data_t;

    // record written on every grant and emitted at the output
    typedef struct packed {
        src_id_t src;
        data_t   data;
    } grant_rec_t;

endpackage

// File: priority_encoder.sv
`timescale 1ns/1ps

module priority_encoder #(
    parameter int WIDTH             = 4,
    // 1: bit 0 wins, 0: top bit wins
    parameter bit LSB_HIGH_PRIORITY = 1'b0
) (
    input  logic [WIDTH-1:0]         input_unencoded,
    output logic                     output_valid,
    output logic [$clog2(WIDTH)-1:0] output_encoded,
    output logic [WIDTH-1:0]         output_unencoded
);

    // tree depth, at least one level of pairs
    localparam int LEVELS = (WIDTH > 2) ? $clog2(WIDTH) : 1;
    localparam int W      = 2 ** LEVELS;

    logic [W-1:0]      input_padded;
    // per level node valid and node index, index bits above the level stay zero
    logic              stage_valid [LEVELS][W/2];
    logic [LEVELS-1:0] stage_enc   [LEVELS][W/2];

    // zero extend to the next power of two
    assign input_padded = W'(input_unencoded);

    // leaf level, one node per input pair
    for (genvar n = 0; n < W / 2; n++) begin : g_leaf
        assign stage_valid[0][n] = input_padded[2*n] | input_padded[2*n+1];
        if (LSB_HIGH_PRIORITY) begin : g_lsb
            // odd bit only chosen when the even bit is clear
            assign stage_enc[0][n] = LEVELS'(!input_padded[2*n]);
        end else begin : g_msb
            assign stage_enc[0][n] = LEVELS'(input_padded[2*n+1]);
        end
    end

    // merge pairs of nodes until one remains
    for (genvar l = 1; l < LEVELS; l++) begin : g_level
        // index bit contributed by picking the upper child
        localparam logic [LEVELS-1:0] HI_BIT = LEVELS'(1) << l;

        for (genvar n = 0; n < (W >> (l + 1)); n++) begin : g_node
            assign stage_valid[l][n] = stage_valid[l-1][2*n] | stage_valid[l-1][2*n+1];
            if (LSB_HIGH_PRIORITY) begin : g_lsb
                // lower child wins whenever it has a set bit
                assign stage_enc[l][n] = stage_valid[l-1][2*n] ?
                                         stage_enc[l-1][2*n] :
                                         (stage_enc[l-1][2*n+1] | HI_BIT);
            end else begin : g_msb
                // upper child wins whenever it has a set bit
                assign stage_enc[l][n] = stage_valid[l-1][2*n+1] ?
                                         (stage_enc[l-1][2*n+1] | HI_BIT) :
                                         stage_enc[l-1][2*n];
            end
        end
    end

    assign output_valid   = stage_valid[LEVELS-1][0];
    assign output_encoded = stage_enc[LEVELS-1][0];

    // one-hot of the winner, all zero with no input bit set
    assign output_unencoded = output_valid ? (WIDTH'(1) << output_encoded) : '0;

endmodule

// File: rr_arbiter.sv
`timescale 1ns/1ps
`include "arb_cfg.svh"

module rr_arbiter
    import arb_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`ARB_NUM_SRC-1:0] req,
    input  req_data_t               req_data,
    input  logic                    full,
    output logic [`ARB_NUM_SRC-1:0] grant,
    output logic                    wr_en,
    output grant_rec_t              wr_rec
);

    localparam int NUM_SRC = `ARB_NUM_SRC;

    // positions above the last winner
    logic [NUM_SRC-1:0] mask;
    logic [NUM_SRC-1:0] mask_next;
    logic [NUM_SRC-1:0] req_masked;

    logic               m_valid;
    src_id_t            m_idx;
    logic [NUM_SRC-1:0] m_oh;
    logic               u_valid;
    src_id_t            u_idx;
    logic [NUM_SRC-1:0] u_oh;

    src_id_t            winner;
    logic [NUM_SRC-1:0] winner_oh;
    logic               do_grant;

    assign req_masked = req & mask;

    // candidates above the last winner
    priority_encoder #(
        .WIDTH             (NUM_SRC),
        .LSB_HIGH_PRIORITY (1'b1)
    ) u_enc_masked (
        .input_unencoded  (req_masked),
        .output_valid     (m_valid),
        .output_encoded   (m_idx),
        .output_unencoded (m_oh)
    );

    // wrap-around choice over all requests
    priority_encoder #(
        .WIDTH             (NUM_SRC),
        .LSB_HIGH_PRIORITY (1'b1)
    ) u_enc_all (
        .input_unencoded  (req),
        .output_valid     (u_valid),
        .output_encoded   (u_idx),
        .output_unencoded (u_oh)
    );

    // masked result first, fall back to the lowest request overall
    assign winner    = m_valid ? m_idx : u_idx;
    assign winner_oh = m_valid ? m_oh : u_oh;

    // no grant while the fifo cannot take the record
    assign do_grant = u_valid & ~full;
    assign grant    = do_grant ? winner_oh : '0;
    assign wr_en    = do_grant;

    assign wr_rec.src  = winner;
    assign wr_rec.data = req_data[winner];

    // mask of every index strictly above the winner
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            mask_next[i] = (i > int'(winner));
        end
    end

    // last starts at 0 so source 0 is masked out first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mask <= ~NUM_SRC'(1);
        end else if (do_grant) begin
            mask <= mask_next;
        end
    end

endmodule

// File: grant_fifo.sv
`timescale 1ns/1ps
`include "arb_cfg.svh"

module grant_fifo
    import arb_pkg::*;
#(
    parameter type payload_t = grant_rec_t,
    parameter int  DEPTH     = `ARB_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  payload_t wr_rec,
    input  logic     rd_en,
    output payload_t rd_rec,
    output logic     full,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t   mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // requests that cannot be served are dropped here
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // head of the queue, visible without a read
    assign rd_rec = mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_rec;
        end
    end

    // pointers wrap at DEPTH so any depth works
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the level unchanged
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: drain_stage.sv
`timescale 1ns/1ps

module drain_stage
    import arb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       drain_en,
    input  logic       empty,
    input  grant_rec_t rd_rec,
    output logic       rd_en,
    output logic       out_valid,
    output grant_rec_t out_rec
);

    // pop whenever allowed and something is stored
    assign rd_en = drain_en & ~empty;

    // one valid pulse per popped record
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;
        end
    end

    // record is captured at the pop edge and held until the next pop
    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_rec <= rd_rec;
        end
    end

endmodule

// File: arb_subsys_top.sv
`timescale 1ns/1ps
`include "arb_cfg.svh"

module arb_subsys_top
    import arb_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`ARB_NUM_SRC-1:0] req,
    input  req_data_t               req_data,
    input  logic                    drain_en,
    output logic [`ARB_NUM_SRC-1:0] grant,
    output logic                    out_valid,
    output grant_rec_t              out_rec
);

    // arbiter to fifo
    logic       wr_en;
    grant_rec_t wr_rec;
    logic       full;

    // fifo to drain stage
    logic       rd_en;
    grant_rec_t rd_rec;
    logic       empty;

    rr_arbiter u_rr_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .full     (full),
        .grant    (grant),
        .wr_en    (wr_en),
        .wr_rec   (wr_rec)
    );

    grant_fifo #(
        .payload_t (grant_rec_t),
        .DEPTH     (`ARB_FIFO_DEPTH)
    ) u_grant_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (wr_en),
        .wr_rec (wr_rec),
        .rd_en  (rd_en),
        .rd_rec (rd_rec),
        .full   (full),
        .empty  (empty)
    );

    drain_stage u_drain_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .drain_en  (drain_en),
        .empty     (empty),
        .rd_rec    (rd_rec),
        .rd_en     (rd_en),
        .out_valid (out_valid),
        .out_rec   (out_rec)
    );

endmodule

// File: arb_subsys_props.sv
`timescale 1ns/1ps
`include "arb_cfg.svh"

module arb_subsys_props (
    input logic                    clk,
    input logic                    rst_n,
    input logic [`ARB_NUM_SRC-1:0] grant,
    input logic                    wr_en,
    input logic                    full,
    input logic                    rd_en,
    input logic                    out_valid
);

    // at most one source wins per cycle
    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
        else $error("more than one grant bit set");

    // a full fifo blocks the arbiter
    a_no_grant_full: assert property (@(posedge clk) disable iff (!rst_n)
        full |-> (grant == '0 && !wr_en))
        else $error("grant given while the fifo is full");

    // each valid pulse comes from exactly one pop on the edge before
    a_valid_from_pop: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(rd_en))
        else $error("out_valid without a pop one cycle earlier");

    // nothing moves right after a reset edge
    a_quiet_reset: assert property (@(posedge clk)
        !rst_n |=> (grant == '0 && !wr_en && !rd_en && !out_valid))
        else $error("activity after a reset edge");

endmodule

bind arb_subsys_top arb_subsys_props u_arb_subsys_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .grant     (grant),
    .wr_en     (wr_en),
    .full      (full),
    .rd_en     (rd_en),
    .out_valid (out_valid)
);

// File: tb_arb_subsys.sv
`timescale 1ns/1ps
`include "arb_cfg.svh"

module tb_arb_subsys
    import arb_pkg::*;
();

    localparam int NUM_SRC  = `ARB_NUM_SRC;
    localparam int DEPTH    = `ARB_FIFO_DEPTH;
    // transfers per phase, random phase counts at most one per cycle
    localparam int N_ROTATE = 4 * NUM_SRC;
    localparam int N_RAND   = 200;
    localparam int N_BP     = DEPTH + 2 * NUM_SRC;
    localparam int N_XFER   = 1 + N_ROTATE + N_RAND + N_BP;
    localparam int WATCHDOG_CYCLES = N_XFER * 40 + 200;

    logic               clk;
    logic               rst_n;
    logic [NUM_SRC-1:0] req;
    req_data_t          req_data;
    logic               drain_en;
    logic [NUM_SRC-1:0] grant;
    logic               out_valid;
    grant_rec_t         out_rec;

    logic [31:0] lcg_state = 32'd41;
    logic [31:0] r;
    int          n_granted;
    int          base;
    // reference model state
    src_id_t     model_last;
    int          model_count;
    logic        exp_valid;
    grant_rec_t  exp_q[$];

    arb_subsys_top u_arb_subsys_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_data  (req_data),
        .drain_en  (drain_en),
        .grant     (grant),
        .out_valid (out_valid),
        .out_rec   (out_rec)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // round robin, first request above last, else lowest request
    function automatic src_id_t next_winner(input logic [NUM_SRC-1:0] req_v, input src_id_t last);
        src_id_t win;
        logic    found;
        win   = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_SRC; i++) begin
            if (!found && req_v[i] && i > int'(last)) begin
                win   = src_id_t'(i);
                found = 1'b1;
            end
        end
        for (int i = 0; i < NUM_SRC; i++) begin
            if (!found && req_v[i]) begin
                win   = src_id_t'(i);
                found = 1'b1;
            end
        end
        return win;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            abort_run("value mismatch");
        end
    endtask

    // one clock of stimulus, granted sources drop req and may request again with new data
    task automatic drive_cycle(input logic allow_new, input logic [NUM_SRC-1:0] new_mask,
                               input logic drain);
        logic [NUM_SRC-1:0] g;
        logic [NUM_SRC-1:0] next_req;
        req_data_t          next_data;
        logic [31:0]        v;
        @(posedge clk);
        g         = grant;
        next_req  = req;
        next_data = req_data;
        n_granted = n_granted + $countones(g);
        for (int i = 0; i < NUM_SRC; i++) begin
            if (g[i]) begin
                next_req[i] = 1'b0;
            end
            if (!next_req[i] && allow_new && new_mask[i]) begin
                v            = rand32();
                next_req[i]  = 1'b1;
                next_data[i] = v[31:16];
            end
        end
        req      <= next_req;
        req_data <= next_data;
        drain_en <= drain;
    endtask

    task automatic stop_and_drain();
        do begin
            drive_cycle(1'b0, '0, 1'b1);
            // look at req and the queue once this edge has settled
            @(negedge clk);
        end while (req != '0 || exp_q.size() != 0);
    endtask

    // monitor, predicts grant and queues the expected record
    always @(posedge clk) begin : monitor
        logic [NUM_SRC-1:0] exp_g;
        src_id_t            w;
        logic               push;
        logic               pop;
        grant_rec_t         rec;
        if (!rst_n) begin
            model_last  = '0;
            model_count = 0;
            exp_valid  <= 1'b0;
        end else begin
            exp_g = '0;
            push  = 1'b0;
            w     = '0;
            if (req != '0 && model_count != DEPTH) begin
                w        = next_winner(req, model_last);
                exp_g[w] = 1'b1;
                push     = 1'b1;
            end
            check_equal("grant", exp_g, grant);
            // pop decision uses the level before this edge's write
            pop = drain_en && (model_count != 0);
            if (push) begin
                rec.src  = w;
                rec.data = req_data[w];
                exp_q.push_back(rec);
                model_last = w;
            end
            model_count = model_count + int'(push) - int'(pop);
            exp_valid  <= pop;
        end
    end

    always @(posedge clk) begin : compare
        grant_rec_t e;
        if (rst_n) begin
            check_equal("out_valid", exp_valid, out_valid);
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("out_valid seen with no record pending");
                end else begin
                    e = exp_q.pop_front();
                    check_equal("out_rec.src", e.src, out_rec.src);
                    check_equal("out_rec.data", e.data, out_rec.data);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("timeout, the test did not finish in time");
    end

    initial begin
        rst_n    <= 1'b0;
        req      <= '0;
        req_data <= '0;
        drain_en <= 1'b0;
        n_granted = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // idle, model expects no grant and no output
        repeat (5) drive_cycle(1'b0, '0, 1'b1);

        // single request from the top source
        drive_cycle(1'b1, NUM_SRC'(1) << (NUM_SRC - 1), 1'b1);
        stop_and_drain();

        // all sources busy, order rotates
        base = n_granted;
        while (n_granted - base < N_ROTATE) begin
            drive_cycle(1'b1, '1, 1'b1);
        end
        stop_and_drain();

        // random requests, data and drain
        for (int c = 0; c < N_RAND; c++) begin
            r = rand32();
            drive_cycle(1'b1, r[31 -: NUM_SRC], r[15]);
        end
        stop_and_drain();

        // fill the fifo with drain off, grants must stop at depth
        base = n_granted;
        while (n_granted - base < DEPTH) begin
            drive_cycle(1'b1, '1, 1'b0);
        end
        repeat (4) drive_cycle(1'b1, '1, 1'b0);
        check_equal("grant count while full", base + DEPTH, n_granted);
        while (n_granted - base < N_BP) begin
            drive_cycle(1'b1, '1, 1'b1);
        end
        stop_and_drain();

        if (exp_q.size() != 0) begin
            abort_run("records still pending at the end of the test");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// File: filelist.f
+incdir+.
arb_pkg.sv
priority_encoder.sv
rr_arbiter.sv
grant_fifo.sv
drain_stage.sv
arb_subsys_top.sv
arb_subsys_props.sv
tb_arb_subsys.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_arb_subsys
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
